/* logic/gx_video_pkg.sv */
// Colour and palette types for the video datapath
package gx_video_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // Palette colour, red 11:8, green 7:4, blue 3:0
    typedef logic [11:0] color12_t;

    typedef logic [3:0] nibble_t;     // One colour component
    typedef logic [4:0] pal_index_t;  // Palette entry number
    typedef logic [1:0] rgb2_t;       // Incoming video component

    // Entries in each palette
    localparam int PAL_ENTRIES = 32;

    //////////////////////////////
    // Field helpers
    //////////////////////////////

    function automatic nibble_t color_red(color12_t c);
        return c[11:8];
    endfunction

    function automatic nibble_t color_green(color12_t c);
        return c[7:4];
    endfunction

    function automatic nibble_t color_blue(color12_t c);
        return c[3:0];
    endfunction

    // Packs three components in palette order
    function automatic color12_t make_color(nibble_t red, nibble_t green, nibble_t blue);
        return {red, green, blue};
    endfunction

endpackage

/* logic/gx_cpu_map_pkg.sv */
// CPU side of the video ASIC
package gx_cpu_map_pkg;

    //////////////////////////////
    // Bus types
    //////////////////////////////

    typedef logic [15:0] cpu_addr_t;  // Z80 address
    typedef logic [7:0]  cpu_data_t;  // Z80 data byte

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Primary palette window 6400h-643Fh, matched on bits 15:6
    localparam logic [9:0] PRIMARY_BASE_HI = 10'h190;

    // Page of the secondary palette and MRER
    localparam logic [7:0] SECONDARY_PAGE = 8'h7F;

    // Low byte offsets within the 7Fxx page
    localparam logic [7:0] SEC_POINTER_LO = 8'h00;  // Entry pointer
    localparam logic [7:0] SEC_LATCH_LO   = 8'h01;  // Red/green latch
    localparam logic [7:0] SEC_COMMIT_LO  = 8'h02;  // Blue and commit, 03h mirrors it

    // Mode and ROM enable register
    localparam logic [15:0] MRER_ADDR = 16'h7F8C;

    // Only the Plus bit of MRER is kept
    localparam int MRER_PLUS_BIT = 7;

endpackage

/* logic/cpu_reg_decode.sv */
`timescale 1ns/1ns

// Turns CPU writes into palette strobes and keeps the MRER Plus bit
module cpu_reg_decode (
    input  logic                      clk_sys,
    input  logic                      reset,

    // CPU write port
    input  gx_cpu_map_pkg::cpu_addr_t cpu_addr,
    input  gx_cpu_map_pkg::cpu_data_t cpu_data,
    input  logic                      cpu_wr,
    input  logic                      plus_mode,    // External Plus request

    // Primary palette strobes
    output logic                      pri_green_wr,
    output logic                      pri_red_blue_wr,
    output gx_video_pkg::pal_index_t  pri_entry,

    // Secondary palette strobes
    output logic                      sec_pointer_wr,
    output logic                      sec_latch_wr,
    output logic                      sec_commit_wr,

    output logic                      plus_select   // Secondary palette in use
);

    logic pri_hit;       // Write inside 6400h-643Fh
    logic sec_page_hit;  // Write inside 7Fxx
    logic mrer_wr;       // Write to 7F8Ch
    logic plus_bit;      // Stored MRER bit 7

    //////////////////////////////
    // Primary palette window
    //////////////////////////////

    assign pri_hit = cpu_wr && (cpu_addr[15:6] == gx_cpu_map_pkg::PRIMARY_BASE_HI);

    // Even byte carries green, odd byte red and blue
    assign pri_green_wr    = pri_hit && !cpu_addr[0];
    assign pri_red_blue_wr = pri_hit && cpu_addr[0];

    // Two bytes per entry
    assign pri_entry = cpu_addr[5:1];

    //////////////////////////////
    // Secondary palette registers
    //////////////////////////////

    assign sec_page_hit = cpu_wr && (cpu_addr[15:8] == gx_cpu_map_pkg::SECONDARY_PAGE);

    assign sec_pointer_wr = sec_page_hit && (cpu_addr[7:0] == gx_cpu_map_pkg::SEC_POINTER_LO);
    assign sec_latch_wr   = sec_page_hit && (cpu_addr[7:0] == gx_cpu_map_pkg::SEC_LATCH_LO);

    // Bit 0 ignored so 7F03h lands on the commit too
    assign sec_commit_wr  = sec_page_hit &&
                            ({cpu_addr[7:1], 1'b0} == gx_cpu_map_pkg::SEC_COMMIT_LO);

    //////////////////////////////
    // Mode register
    //////////////////////////////

    assign mrer_wr = cpu_wr && (cpu_addr == gx_cpu_map_pkg::MRER_ADDR);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            plus_bit <= 1'b0;                                       // Classic mode out of reset
        end else if (mrer_wr) begin
            plus_bit <= cpu_data[gx_cpu_map_pkg::MRER_PLUS_BIT];    // Mode and ROM bits dropped
        end
    end

    // Either source forces Plus mode
    // External input acts without a clock edge
    assign plus_select = plus_bit | plus_mode;

endmodule

/* logic/primary_palette.sv */
`timescale 1ns/1ns

// Classic 32-entry palette, each entry written as two bytes
module primary_palette (
    input  logic                      clk_sys,
    input  logic                      reset,

    // Write side from the decoder
    input  logic                      green_wr,     // Even byte
    input  logic                      red_blue_wr,  // Odd byte
    input  gx_video_pkg::pal_index_t  entry,
    input  gx_cpu_map_pkg::cpu_data_t cpu_data,

    // Read side from the video index
    input  logic [3:0]                read_index,
    output gx_video_pkg::color12_t    color
);

    gx_video_pkg::color12_t entries [gx_video_pkg::PAL_ENTRIES];

    //////////////////////////////
    // Byte writes
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            // All entries black
            for (int i = 0; i < gx_video_pkg::PAL_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (green_wr) begin
                entries[entry][7:4] <= cpu_data[3:0];   // Green only, red/blue kept
            end
            if (red_blue_wr) begin
                entries[entry][11:8] <= cpu_data[7:4];  // Red from high nibble
                entries[entry][3:0]  <= cpu_data[3:0];  // Blue from low nibble
            end
        end
    end

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // Index is 4 bits so entries 16-31 never reach the screen
    assign color = entries[{1'b0, read_index}];

endmodule

/* logic/secondary_palette.sv */
`timescale 1ns/1ns

// Plus palette behind the 7F00h-7F03h pointer/latch/commit registers
module secondary_palette (
    input  logic                      clk_sys,
    input  logic                      reset,

    // Register strobes
    input  logic                      pointer_wr,  // 7F00h
    input  logic                      latch_wr,    // 7F01h
    input  logic                      commit_wr,   // 7F02h or 7F03h
    input  gx_cpu_map_pkg::cpu_data_t cpu_data,

    // Video lookup
    input  gx_video_pkg::pal_index_t  read_index,
    output gx_video_pkg::color12_t    color
);

    gx_video_pkg::pal_index_t pointer;       // Next entry to commit
    gx_video_pkg::nibble_t    latch_red;     // Held until the commit
    gx_video_pkg::nibble_t    latch_green;
    gx_video_pkg::color12_t   entries [gx_video_pkg::PAL_ENTRIES];

    //////////////////////////////
    // Pointer and latches
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pointer     <= '0;
            latch_red   <= '0;
            latch_green <= '0;
        end else begin
            if (pointer_wr) begin
                pointer <= cpu_data[4:0];  // Upper data bits ignored
            end else if (commit_wr) begin
                // Auto-increment, last entry wraps to 0
                if (pointer == 5'(gx_video_pkg::PAL_ENTRIES - 1)) begin
                    pointer <= '0;
                end else begin
                    pointer <= pointer + 5'd1;
                end
            end

            if (latch_wr) begin
                latch_red   <= cpu_data[7:4];
                latch_green <= cpu_data[3:0];
            end
        end
    end

    //////////////////////////////
    // Entry storage
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < gx_video_pkg::PAL_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (commit_wr) begin
            // Blue sits in the high nibble of the commit byte
            entries[pointer] <= gx_video_pkg::make_color(latch_red, latch_green,
                                                         cpu_data[7:4]);
        end
    end

    // Full 5-bit lookup, no latency
    assign color = entries[read_index];

endmodule

/* logic/pixel_output.sv */
`timescale 1ns/1ns

// Palette choice and the output register stage
module pixel_output (
    input  logic                   clk_sys,
    input  logic                   reset,

    input  logic                   plus_select,      // High picks the secondary palette
    input  gx_video_pkg::color12_t primary_color,
    input  gx_video_pkg::color12_t secondary_color,

    // 4 bits per gun
    output gx_video_pkg::nibble_t  r_out,
    output gx_video_pkg::nibble_t  g_out,
    output gx_video_pkg::nibble_t  b_out
);

    gx_video_pkg::color12_t selected;  // Colour before the register

    //////////////////////////////
    // Palette select
    //////////////////////////////

    assign selected = plus_select ? secondary_color : primary_color;

    //////////////////////////////
    // Output register
    //////////////////////////////

    // One cycle from index to pins
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_out <= '0;  // Black out of reset
            g_out <= '0;
            b_out <= '0;
        end else begin
            r_out <= gx_video_pkg::color_red(selected);
            g_out <= gx_video_pkg::color_green(selected);
            b_out <= gx_video_pkg::color_blue(selected);
        end
    end

endmodule

/* logic/gx_video_top.sv */
`timescale 1ns/1ns

// Palette and colour output path of the Plus video ASIC
module gx_video_top (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      plus_mode,  // Force Plus mode from outside

    // CPU write port
    input  gx_cpu_map_pkg::cpu_addr_t cpu_addr,
    input  gx_cpu_map_pkg::cpu_data_t cpu_data,
    input  logic                      cpu_wr,

    // 2-bit video from the CRTC side
    input  gx_video_pkg::rgb2_t       r_in,
    input  gx_video_pkg::rgb2_t       g_in,
    input  gx_video_pkg::rgb2_t       b_in,

    // Registered colour
    output gx_video_pkg::nibble_t     r_out,
    output gx_video_pkg::nibble_t     g_out,
    output gx_video_pkg::nibble_t     b_out
);

    logic                     pri_green_wr;
    logic                     pri_red_blue_wr;
    gx_video_pkg::pal_index_t pri_entry;
    logic                     sec_pointer_wr;
    logic                     sec_latch_wr;
    logic                     sec_commit_wr;
    logic                     plus_select;
    gx_video_pkg::pal_index_t color_index;      // Lookup index for both palettes
    gx_video_pkg::color12_t   primary_color;
    gx_video_pkg::color12_t   secondary_color;

    // Low 5 bits of {r,g,b}, red gives only its bit 0
    assign color_index = {r_in[0], g_in, b_in};

    //////////////////////////////
    // Register decode
    //////////////////////////////

    cpu_reg_decode cpu_reg_decode_i (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .cpu_addr        (cpu_addr),
        .cpu_data        (cpu_data),
        .cpu_wr          (cpu_wr),
        .plus_mode       (plus_mode),
        .pri_green_wr    (pri_green_wr),
        .pri_red_blue_wr (pri_red_blue_wr),
        .pri_entry       (pri_entry),
        .sec_pointer_wr  (sec_pointer_wr),
        .sec_latch_wr    (sec_latch_wr),
        .sec_commit_wr   (sec_commit_wr),
        .plus_select     (plus_select)
    );

    //////////////////////////////
    // Palettes and output
    //////////////////////////////

    primary_palette primary_palette_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .green_wr    (pri_green_wr),
        .red_blue_wr (pri_red_blue_wr),
        .entry       (pri_entry),
        .cpu_data    (cpu_data),
        .read_index  (color_index[3:0]),  // 16 colours in classic mode
        .color       (primary_color)
    );

    secondary_palette secondary_palette_i (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .pointer_wr (sec_pointer_wr),
        .latch_wr   (sec_latch_wr),
        .commit_wr  (sec_commit_wr),
        .cpu_data   (cpu_data),
        .read_index (color_index),
        .color      (secondary_color)
    );

    pixel_output pixel_output_i (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .plus_select     (plus_select),
        .primary_color   (primary_color),
        .secondary_color (secondary_color),
        .r_out           (r_out),
        .g_out           (g_out),
        .b_out           (b_out)
    );

endmodule

/* dv/gx_video_model.svh */
`ifndef GX_VIDEO_MODEL_SVH
`define GX_VIDEO_MODEL_SVH

//////////////////////////////
// Reference palette state
//////////////////////////////

gx_video_pkg::color12_t ref_primary [32];    // Classic palette
gx_video_pkg::color12_t ref_secondary [32];  // Plus palette
gx_video_pkg::pal_index_t ref_pointer;       // Next commit target
gx_video_pkg::nibble_t ref_red;              // Latched at 7F01h
gx_video_pkg::nibble_t ref_green;
logic ref_plus;                              // MRER bit 7

// Everything back to black
function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        ref_primary[i] = '0;
        ref_secondary[i] = '0;
    end
    ref_pointer = '0;
    ref_red = '0;
    ref_green = '0;
    ref_plus = 1'b0;
endfunction

// Colour picked for one set of video inputs
function automatic gx_video_pkg::color12_t lookup_color(input gx_video_pkg::rgb2_t r,
                                                        input gx_video_pkg::rgb2_t g,
                                                        input gx_video_pkg::rgb2_t b,
                                                        input logic pm);
    gx_video_pkg::pal_index_t idx;
    idx = {r[0], g, b};                      // Red bit 1 drops out
    if (pm || ref_plus) begin
        return ref_secondary[idx];
    end
    return ref_primary[{1'b0, idx[3:0]}];    // 16 colours only
endfunction

// One CPU write as the register map defines it
function automatic void apply_write(input gx_cpu_map_pkg::cpu_addr_t addr,
                                    input gx_cpu_map_pkg::cpu_data_t data);
    gx_video_pkg::pal_index_t entry;
    entry = addr[5:1];
    if (addr >= 16'h6400 && addr <= 16'h643F) begin
        if (addr[0]) begin
            ref_primary[entry][11:8] = data[7:4];  // Odd byte, red
            ref_primary[entry][3:0] = data[3:0];   // and blue
        end else begin
            ref_primary[entry][7:4] = data[3:0];   // Even byte, green
        end
    end else begin
        case (addr)
            16'h7F00: ref_pointer = data[4:0];
            16'h7F01: begin
                ref_red = data[7:4];
                ref_green = data[3:0];
            end
            16'h7F02, 16'h7F03: begin
                ref_secondary[ref_pointer] = {ref_red, ref_green, data[7:4]};
                ref_pointer = ref_pointer + 5'd1;  // Wraps at 32
            end
            16'h7F8C: ref_plus = data[7];
            default: ;
        endcase
    end
endfunction

`endif

/* dv/gx_video_tb.sv */
`timescale 1ns/1ns

module gx_video_tb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int DIRECTED_CYCLES = 300;  // Upper bound for the directed part
    localparam int RANDOM_CYCLES = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

    logic clk_sys = 1'b0;
    logic reset;
    logic plus_mode;
    gx_cpu_map_pkg::cpu_addr_t cpu_addr;
    gx_cpu_map_pkg::cpu_data_t cpu_data;
    logic cpu_wr;
    gx_video_pkg::rgb2_t r_in;
    gx_video_pkg::rgb2_t g_in;
    gx_video_pkg::rgb2_t b_in;
    gx_video_pkg::nibble_t r_out;
    gx_video_pkg::nibble_t g_out;
    gx_video_pkg::nibble_t b_out;

    // Expected colour, from drive edge to check
    gx_video_pkg::color12_t pending_color;
    logic pending_valid = 1'b0;
    string pending_what;
    gx_video_pkg::color12_t armed_color;
    logic armed_valid = 1'b0;
    string armed_what;
    int errors = 0;
    int checks = 0;

    `include "gx_video_model.svh"

    gx_video_top gx_video_top_i (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .plus_mode (plus_mode),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .cpu_wr    (cpu_wr),
        .r_in      (r_in),
        .g_in      (g_in),
        .b_in      (b_in),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out)
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_color(input gx_video_pkg::color12_t got,
                               input gx_video_pkg::color12_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %03h expected %03h", $time, what, got, exp);
        end
    endtask

    // Outputs settle after the edge, so compare mid-cycle
    always @(negedge clk_sys) begin
        if (armed_valid) begin
            check_color({r_out, g_out, b_out}, armed_color, armed_what);
        end
        armed_valid = pending_valid;  // One cycle of latency
        armed_color = pending_color;
        armed_what = pending_what;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // One clock of inputs, model updated at the same edge
    task automatic drive_cycle(input gx_cpu_map_pkg::cpu_addr_t addr,
                               input gx_cpu_map_pkg::cpu_data_t data, input logic wr,
                               input gx_video_pkg::rgb2_t r, input gx_video_pkg::rgb2_t g,
                               input gx_video_pkg::rgb2_t b, input logic pm);
        @(posedge clk_sys);
        cpu_addr <= addr;
        cpu_data <= data;
        cpu_wr <= wr;
        r_in <= r;
        g_in <= g;
        b_in <= b;
        plus_mode <= pm;
        pending_color = lookup_color(r, g, b, pm);  // State before this write
        pending_what = $sformatf("index %0d plus_mode %0b", {r[0], g, b}, pm);
        pending_valid = 1'b1;
        if (wr) begin
            apply_write(addr, data);
        end
    endtask

    // Idle bus, video set to one index; red bit 1 is noise
    task automatic show_index(input gx_video_pkg::pal_index_t idx, input logic pm);
        drive_cycle(16'h0000, 8'h00, 1'b0, {1'($urandom), idx[4]}, idx[3:2], idx[1:0], pm);
    endtask

    task automatic write_reg(input gx_cpu_map_pkg::cpu_addr_t addr,
                             input gx_cpu_map_pkg::cpu_data_t data, input logic pm);
        drive_cycle(addr, data, 1'b1, 2'($urandom), 2'($urandom), 2'($urandom), pm);
    endtask

    // Register map hits mostly, some stray addresses
    function automatic gx_cpu_map_pkg::cpu_addr_t random_address();
        case ($urandom % 8)
            0, 1: return 16'h6400 | 16'($urandom % 64);
            2: return 16'h7F00;
            3: return 16'h7F01;
            4: return 16'h7F02 | 16'($urandom % 2);  // Commit or its mirror
            5: return 16'h7F8C;
            6: return {8'h7F, 8'($urandom)};
            default: return 16'($urandom);
        endcase
    endfunction

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic after_reset_black();
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 32; i++) begin
                show_index(5'(i), 1'(p));
            end
        end
    endtask

    task automatic primary_writes();
        write_reg(16'h640A, 8'hF7, 1'b0);  // Entry 5 green, high nibble ignored
        write_reg(16'h640B, 8'hA3, 1'b0);  // Entry 5 red and blue
        show_index(5'd5, 1'b0);
        show_index(5'd21, 1'b0);           // Aliases entry 5
        write_reg(16'h640A, 8'h0C, 1'b0);  // Green only
        show_index(5'd5, 1'b0);
        write_reg(16'h643F, 8'h5E, 1'b0);  // Entry 31, never on screen
        write_reg(16'h641D, 8'h96, 1'b0);  // Entry 14 red/blue, green stays 0
        show_index(5'd14, 1'b0);
        show_index(5'd31, 1'b0);           // Reads entry 15, not 31
    endtask

    task automatic secondary_writes();
        write_reg(16'h7F00, 8'h04, 1'b1);  // Pointer 4
        write_reg(16'h7F01, 8'h5A, 1'b1);
        write_reg(16'h7F02, 8'hC0, 1'b1);
        write_reg(16'h7F01, 8'h12, 1'b1);
        write_reg(16'h7F03, 8'h30, 1'b1);  // Mirror commits entry 5
        show_index(5'd4, 1'b1);
        show_index(5'd5, 1'b1);
        show_index(5'd6, 1'b1);
        // Wrap from the last entry
        write_reg(16'h7F00, 8'hFF, 1'b1);
        write_reg(16'h7F01, 8'h8B, 1'b1);
        write_reg(16'h7F02, 8'h10, 1'b1);
        write_reg(16'h7F02, 8'h20, 1'b1);
        write_reg(16'h7F02, 8'h30, 1'b1);
        show_index(5'd31, 1'b1);
        show_index(5'd0, 1'b1);
        show_index(5'd1, 1'b1);
    endtask

    task automatic mode_select();
        write_reg(16'h7F00, 8'h14, 1'b0);  // Entries 20 and 21 differ from 4 and 5
        write_reg(16'h7F01, 8'hE1, 1'b0);
        write_reg(16'h7F02, 8'h70, 1'b0);
        write_reg(16'h7F02, 8'hF0, 1'b0);
        write_reg(16'h7F8C, 8'h80, 1'b0);  // Plus through MRER
        for (int i = 0; i < 32; i++) begin
            show_index(5'(i), 1'b0);
        end
        write_reg(16'h7F8C, 8'h7F, 1'b0);  // Plus bit cleared
        for (int i = 0; i < 32; i++) begin
            show_index(5'(i), 1'b1);       // Plus through the pin
        end
        for (int i = 0; i < 32; i++) begin
            show_index(5'(i), 1'b0);       // Classic, 16-31 alias 0-15
        end
    endtask

    task automatic random_traffic();
        logic pm;
        pm = 1'b0;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if ($urandom % 32 == 0) begin
                pm = !pm;
            end
            drive_cycle(random_address(), 8'($urandom), 1'($urandom),
                        2'($urandom), 2'($urandom), 2'($urandom), pm);
        end
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    initial begin
        void'($urandom(32'h174bc0d5));
        reset <= 1'b1;
        plus_mode <= 1'b0;
        cpu_addr <= '0;
        cpu_data <= '0;
        cpu_wr <= 1'b0;
        r_in <= '0;
        g_in <= '0;
        b_in <= '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        reset_model();
        after_reset_black();
        primary_writes();
        secondary_writes();
        mode_select();
        random_traffic();
        show_index(5'd0, 1'b0);  // Flush the last expected colours
        show_index(5'd0, 1'b0);
        @(posedge clk_sys);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Twice the expected run length
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not complete in %0d cycles", 2 * TOTAL_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* src.f */
+incdir+dv
logic/gx_video_pkg.sv
logic/gx_cpu_map_pkg.sv
logic/cpu_reg_decode.sv
logic/primary_palette.sv
logic/secondary_palette.sv
logic/pixel_output.sv
logic/gx_video_top.sv
dv/gx_video_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the palette testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f src.f \
    --top-module gx_video_tb --Mdir obj_dir -o gx_video_sim
./obj_dir/gx_video_sim > sim.log 2>&1
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
